//--- src/stream_pkg.sv
package stream_pkg;

	// Four bytes per beat keeps every IPv4 header word aligned to a single beat
	localparam int BEAT_BYTES = 4;

	// Width of the data field of one beat
	localparam int BEAT_WIDTH = BEAT_BYTES * 8;

	// One transfer on any stream port of the design
	// Byte 0 of the packet sits in data[7:0], byte 3 in data[31:24]
	typedef struct packed {
		logic [BEAT_WIDTH-1:0] data;
		// Marks the final beat of a packet
		logic                  last;
	} beat_t;

endpackage

//--- src/ipv4_pkg.sv
package ipv4_pkg;

	// Header word indices, counted in 32-bit words from the start of the packet
	// The width matches the IHL field so they compare directly with the word counter
	localparam logic [3:0] WORD_PROTO = 4'd2;
	localparam logic [3:0] WORD_SRC   = 4'd3;
	localparam logic [3:0] WORD_DST   = 4'd4;

	// One header word, seen either as raw bits or through the layout of word 0 or word 2
	// Fields are listed from the top byte down, so byte 0 of the word ends up at the bottom
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			// Total length arrives in network order, high byte first
			logic [7:0] total_len_lo;
			logic [7:0] total_len_hi;
			logic [7:0] tos;
			logic [3:0] version;
			// Header length in 32-bit words
			logic [3:0] ihl;
		} w0;
		struct packed {
			logic [15:0] checksum;
			logic [7:0]  protocol;
			logic [7:0]  ttl;
		} w2;
	} hdr_word_u;

	// Per-packet information handed out next to the payload
	typedef struct packed {
		// Payload size in bytes, header and options excluded
		logic [15:0] payload_length;
		logic [7:0]  protocol;
		logic [31:0] src_ip;
		logic [31:0] dst_ip;
	} meta_t;

endpackage

//--- src/beat_fifo.sv
`timescale 1ns/10ps

module beat_fifo
#(
	parameter int DEPTH = 16
) (
	input  logic              clk,
	input  logic              sresetn,
	input  logic              push,
	input  stream_pkg::beat_t push_beat,
	input  logic              pop,
	output stream_pkg::beat_t pop_beat,
	output logic              empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	stream_pkg::beat_t mem [DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;

	// Head of the queue is visible without a read latency
	assign pop_beat = mem[rd_ptr];
	assign empty    = (count == '0);

	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			// Pointers wrap explicitly so a depth that is not a power of two still works
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CNT_W'(push) - CNT_W'(pop);
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			mem[wr_ptr] <= push_beat;
		end
	end

endmodule

//--- src/frame_dispatcher.sv
`timescale 1ns/10ps

module frame_dispatcher
#(
	parameter int NUM_LANES  = 4,
	parameter int FIFO_DEPTH = 16
) (
	input  logic                   clk,
	input  logic                   sresetn,

	input  logic                   in_valid,
	output logic                   in_ready,
	input  stream_pkg::beat_t      in_beat,

	output logic [NUM_LANES-1:0]   lane_push,
	output stream_pkg::beat_t      lane_beat,
	input  logic [NUM_LANES-1:0]   credit_return
);

	localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
	// A counter must hold the full FIFO depth, not just depth minus one
	localparam int CRED_W = $clog2(FIFO_DEPTH + 1);

	logic [LANE_W-1:0]    cur_lane;
	logic [CRED_W-1:0]    credits [NUM_LANES];
	logic                 accept;
	logic [NUM_LANES-1:0] take;

	// One credit stands for one free slot in the lane FIFO
	assign in_ready = (credits[cur_lane] != '0);
	assign accept   = in_valid && in_ready;

	// One-hot mask of the lane that receives the beat accepted this cycle
	assign take = accept ? (NUM_LANES'(1) << cur_lane) : '0;

	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			cur_lane  <= '0;
			lane_push <= '0;
			for (int i = 0; i < NUM_LANES; i++)
			begin
				credits[i] <= CRED_W'(FIFO_DEPTH);
			end
		end
		else
		begin
			// The write strobe follows the accepted beat by exactly one cycle
			lane_push <= take;

			// A push and a return on the same lane in one cycle cancel out
			for (int i = 0; i < NUM_LANES; i++)
			begin
				credits[i] <= credits[i] - CRED_W'(take[i]) + CRED_W'(credit_return[i]);
			end

			// Move on only at a packet boundary so no packet is split across lanes
			if (accept && in_beat.last)
			begin
				if (cur_lane == LANE_W'(NUM_LANES - 1))
					cur_lane <= '0;
				else
					cur_lane <= cur_lane + 1'b1;
			end
		end
	end

	// Shared bus toward all lanes, only the strobed lane samples it
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			lane_beat <= in_beat;
		end
	end

endmodule

//--- src/ip_deframer_lane.sv
`timescale 1ns/10ps

module ip_deframer_lane
#(
	parameter int FIFO_DEPTH = 16
) (
	input  logic              clk,
	input  logic              sresetn,

	input  logic              push,
	input  stream_pkg::beat_t push_beat,
	output logic              credit_return,

	output logic              lane_valid,
	input  logic              lane_ready,
	output stream_pkg::beat_t lane_out_beat,
	output ipv4_pkg::meta_t   lane_meta
);

	stream_pkg::beat_t   head;
	logic                empty;
	logic                pop;
	logic                header_done;
	ipv4_pkg::hdr_word_u hdr;

	// Index of the head word within its packet
	// It stops counting once the header is behind it
	logic [3:0] word_ctr;
	// Holding IHL minus one lets a full 4-bit counter still step past it
	logic [3:0] ihl_last;

	beat_fifo
	#(
		.DEPTH(FIFO_DEPTH)
	) u_beat_fifo (
		.clk      (clk),
		.sresetn  (sresetn),
		.push     (push),
		.push_beat(push_beat),
		.pop      (pop),
		.pop_beat (head),
		.empty    (empty)
	);

	// The same bits are read through the w0 or w2 view depending on the word index
	assign hdr.raw = head.data;

	// The counter is zero after reset and after every last, and zero never exceeds ihl_last
	// So the first word of a packet is never taken as payload
	assign header_done = (word_ctr > ihl_last);

	// Header and option words drain freely while payload words wait for the collector
	assign pop = !empty && (header_done ? lane_ready : 1'b1);

	assign lane_valid    = header_done && !empty;
	assign lane_out_beat = head;

	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			word_ctr      <= '0;
			ihl_last      <= '0;
			credit_return <= 1'b0;
		end
		else
		begin
			// Every popped beat frees one slot that goes back to the dispatcher
			credit_return <= pop;

			if (pop)
			begin
				if (word_ctr == 4'd0)
					ihl_last <= hdr.w0.ihl - 4'd1;

				// The next beat starts a fresh packet
				if (head.last)
					word_ctr <= '0;
				else if (!header_done)
					word_ctr <= word_ctr + 4'd1;
			end
		end
	end

	// Fields are captured as the header goes by and held for the whole payload
	always_ff @(posedge clk)
	begin
		if (pop && !header_done)
		begin
			case (word_ctr)
				4'd0:
				begin
					// Total length minus header length in bytes
					lane_meta.payload_length <= {hdr.w0.total_len_hi, hdr.w0.total_len_lo}
						- {10'd0, hdr.w0.ihl, 2'b00};
				end
				ipv4_pkg::WORD_PROTO: lane_meta.protocol <= hdr.w2.protocol;
				ipv4_pkg::WORD_SRC:   lane_meta.src_ip   <= hdr.raw;
				ipv4_pkg::WORD_DST:   lane_meta.dst_ip   <= hdr.raw;
				// Word 1 and any option words carry nothing we keep
				default: ;
			endcase
		end
	end

endmodule

//--- src/payload_collector.sv
`timescale 1ns/10ps

module payload_collector
#(
	parameter int NUM_LANES = 4
) (
	input  logic                 clk,
	input  logic                 sresetn,

	input  logic [NUM_LANES-1:0] lane_valid,
	output logic [NUM_LANES-1:0] lane_ready,
	input  stream_pkg::beat_t    lane_out_beat [NUM_LANES],
	input  ipv4_pkg::meta_t      lane_meta [NUM_LANES],

	output logic                 out_valid,
	input  logic                 out_ready,
	output stream_pkg::beat_t    out_beat,
	output ipv4_pkg::meta_t      out_meta
);

	localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

	logic [LANE_W-1:0] cur_lane;

	// Plain mux of the selected lane, no storage on the output path
	assign out_valid = lane_valid[cur_lane];
	assign out_beat  = lane_out_beat[cur_lane];
	assign out_meta  = lane_meta[cur_lane];

	// Only the selected lane sees the downstream ready, all others are held
	always_comb
	begin
		lane_ready = '0;
		lane_ready[cur_lane] = out_ready;
	end

	// Same visiting order as the dispatcher, so packets leave in arrival order
	always_ff @(posedge clk)
	begin
		if (!sresetn)
		begin
			cur_lane <= '0;
		end
		else
		begin
			if (out_valid && out_ready && out_beat.last)
			begin
				if (cur_lane == LANE_W'(NUM_LANES - 1))
					cur_lane <= '0;
				else
					cur_lane <= cur_lane + 1'b1;
			end
		end
	end

endmodule

//--- src/ip_deframer_array.sv
`timescale 1ns/10ps

module ip_deframer_array
#(
	parameter int NUM_LANES  = 4,
	parameter int FIFO_DEPTH = 16
) (
	input  logic              clk,
	input  logic              sresetn,

	input  logic              in_valid,
	output logic              in_ready,
	input  stream_pkg::beat_t in_beat,

	output logic              out_valid,
	input  logic              out_ready,
	output stream_pkg::beat_t out_beat,
	output ipv4_pkg::meta_t   out_meta
);

	logic [NUM_LANES-1:0] lane_push;
	logic [NUM_LANES-1:0] credit_return;
	stream_pkg::beat_t    lane_beat;

	logic [NUM_LANES-1:0] lane_valid;
	logic [NUM_LANES-1:0] lane_ready;
	stream_pkg::beat_t    lane_out_beat [NUM_LANES];
	ipv4_pkg::meta_t      lane_meta [NUM_LANES];

	frame_dispatcher
	#(
		.NUM_LANES (NUM_LANES),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_frame_dispatcher (
		.clk          (clk),
		.sresetn      (sresetn),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.in_beat      (in_beat),
		.lane_push    (lane_push),
		.lane_beat    (lane_beat),
		.credit_return(credit_return)
	);

	// All lanes share the dispatcher bus and pick up beats by their own strobe
	for (genvar i = 0; i < NUM_LANES; i++)
	begin : g_lane
		ip_deframer_lane
		#(
			.FIFO_DEPTH(FIFO_DEPTH)
		) u_ip_deframer_lane (
			.clk          (clk),
			.sresetn      (sresetn),
			.push         (lane_push[i]),
			.push_beat    (lane_beat),
			.credit_return(credit_return[i]),
			.lane_valid   (lane_valid[i]),
			.lane_ready   (lane_ready[i]),
			.lane_out_beat(lane_out_beat[i]),
			.lane_meta    (lane_meta[i])
		);
	end

	payload_collector
	#(
		.NUM_LANES(NUM_LANES)
	) u_payload_collector (
		.clk          (clk),
		.sresetn      (sresetn),
		.lane_valid   (lane_valid),
		.lane_ready   (lane_ready),
		.lane_out_beat(lane_out_beat),
		.lane_meta    (lane_meta),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.out_beat     (out_beat),
		.out_meta     (out_meta)
	);

endmodule

//--- dv/tb_ip_deframer_array.sv
`timescale 1ns/10ps

module tb_ip_deframer_array;

	localparam int NUM_LANES  = 4;
	localparam int FIFO_DEPTH = 16;

	logic              clk       = 1'b0;
	logic              sresetn   = 1'b0;
	logic              in_valid  = 1'b0;
	logic              in_ready;
	stream_pkg::beat_t in_beat   = '0;
	logic              out_valid;
	logic              out_ready = 1'b0;
	stream_pkg::beat_t out_beat;
	ipv4_pkg::meta_t   out_meta;

	// Beats still to be driven, then the payload beats and metadata still to come out
	stream_pkg::beat_t in_q[$];
	stream_pkg::beat_t exp_q[$];
	ipv4_pkg::meta_t   meta_q[$];

	stream_pkg::beat_t exp_beat;
	string             cur_test;
	int                errors;
	int                test_errors;
	int                tests_run;
	int                submitted_beats;
	int                accepted_beats;
	// 0 keeps the output always ready, 1 makes it ready about 30% of the time
	int                ready_mode;
	logic              stall     = 1'b0;
	logic              saw_full  = 1'b0;

	always #2 clk = ~clk;

	ip_deframer_array
	#(
		.NUM_LANES (NUM_LANES),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_ip_deframer_array (
		.clk      (clk),
		.sresetn  (sresetn),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_beat  (in_beat),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_beat (out_beat),
		.out_meta (out_meta)
	);

	// Metadata that the lane must report, built from the header fields alone
	function automatic ipv4_pkg::meta_t expected_meta(input int ihl, input int total_len,
		input logic [7:0] proto, input logic [31:0] src, input logic [31:0] dst);
		ipv4_pkg::meta_t m;
		// Everything after IHL header words is payload
		m.payload_length = 16'(total_len - 4 * ihl);
		m.protocol       = proto;
		m.src_ip         = src;
		m.dst_ip         = dst;
		return m;
	endfunction

	task automatic report_mismatch(input string field, input logic [87:0] expected,
		input logic [87:0] actual);
		$display("CHECK FAILED %s %s expected=%h actual=%h", cur_test, field, expected, actual);
		errors++;
		test_errors++;
	endtask

	task automatic report_failure(input string what);
		$display("ERROR in %s: %s", cur_test, what);
		errors++;
		test_errors++;
	endtask

	// One packet, header words in network byte order with byte 0 in bits 7:0
	task automatic build_packet(input int ihl, input int words);
		stream_pkg::beat_t b;
		int                total_len;
		logic [7:0]        proto;
		logic [31:0]       src;
		logic [31:0]       dst;
		total_len = 4 * (ihl + words);
		proto     = 8'($urandom);
		src       = $urandom;
		dst       = $urandom;
		for (int w = 0; w < ihl + words; w++)
		begin
			b.last = (w == ihl + words - 1);
			case (w)
				// Version 4 and IHL share byte 0, total length is high byte first
				0: b.data = {8'(total_len), 8'(total_len >> 8), 8'($urandom), 4'h4, 4'(ihl)};
				// TTL in byte 0, protocol in byte 1, checksum left random
				2: b.data = {16'($urandom), proto, 8'($urandom)};
				3: b.data = src;
				4: b.data = dst;
				// Word 1, the options and the payload are all random
				default: b.data = $urandom;
			endcase
			in_q.push_back(b);
			if (w >= ihl)
				exp_q.push_back(b);
		end
		meta_q.push_back(expected_meta(ihl, total_len, proto, src, dst));
		submitted_beats += ihl + words;
	endtask

	// Holds each beat until the DUT takes it
	task automatic drive_beats();
		stream_pkg::beat_t b;
		@(posedge clk);
		while (in_q.size() > 0)
		begin
			b = in_q.pop_front();
			in_valid <= 1'b1;
			in_beat  <= b;
			@(negedge clk);
			while (!in_ready)
				@(negedge clk);
			@(posedge clk);
		end
		in_valid <= 1'b0;
	endtask

	task automatic run_packets(input int count, input int ihl_lo, input int ihl_hi,
		input int words_lo, input int words_hi, input int mode);
		int ihl;
		int words;
		int bound;
		int stalled_count;
		// Header beats of the first packet in each lane drain even while the output is stuck
		bound = NUM_LANES * FIFO_DEPTH;
		for (int k = 0; k < count; k++)
		begin
			ihl   = $urandom_range(ihl_hi, ihl_lo);
			words = $urandom_range(words_hi, words_lo);
			if (k < NUM_LANES)
				bound += ihl;
			build_packet(ihl, words);
		end
		ready_mode <= (mode == 1) ? 1 : 0;
		stall      <= (mode == 2);
		// Let out_ready settle into the new mode before traffic starts
		repeat (2) @(posedge clk);
		accepted_beats = 0;
		fork
			drive_beats();
			begin
				if (mode == 2)
				begin
					repeat (200) @(posedge clk);
					stalled_count = accepted_beats;
					stall <= 1'b0;
					if (stalled_count > bound)
						report_failure($sformatf("%0d beats accepted during the stall, limit %0d",
							stalled_count, bound));
				end
			end
		join
		while (exp_q.size() > 0)
			@(negedge clk);
		// Anything still valid now would be a duplicate or a stray beat
		repeat (4) @(negedge clk);
		if (out_valid)
			report_failure("output still valid after every expected beat came out");
	endtask

	task automatic start_test(input string name);
		cur_test    = name;
		test_errors = 0;
		saw_full    = 1'b0;
	endtask

	task automatic finish_test(input int packets);
		$display("%-16s packets=%0d errors=%0d", cur_test, packets, test_errors);
		tests_run++;
	endtask

	// Output back-pressure, held low through reset and through a stall window
	always @(posedge clk)
	begin
		if (!sresetn || stall)
			out_ready <= 1'b0;
		else if (ready_mode == 1)
			out_ready <= (($urandom % 10) < 3);
		else
			out_ready <= 1'b1;
	end

	// Inputs are stable at the falling edge, so this sees the transfer of the next rising edge
	always @(negedge clk)
	begin
		if (in_valid && in_ready)
			accepted_beats++;
		if (in_valid && !in_ready)
			saw_full = 1'b1;
	end

	// Compares every output transfer against the head of the expected queues
	always @(negedge clk)
	begin
		if (sresetn && out_valid && out_ready)
		begin
			if (exp_q.size() == 0 || meta_q.size() == 0)
			begin
				report_failure("output beat arrived with no packet expected");
			end
			else
			begin
				exp_beat = exp_q.pop_front();
				if (out_beat.data !== exp_beat.data)
					report_mismatch("data", 88'(exp_beat.data), 88'(out_beat.data));
				if (out_beat.last !== exp_beat.last)
					report_mismatch("last", 88'(exp_beat.last), 88'(out_beat.last));
				if (out_meta !== meta_q[0])
					report_mismatch("meta", meta_q[0], out_meta);
				// Metadata stays the same for the whole packet
				if (exp_beat.last)
					void'(meta_q.pop_front());
			end
		end
	end

	// Budget grows with each packet handed to the DUT
	initial
	begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles <= 40 * submitted_beats + 2000)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycles);
		$display("*** FAILED ***");
		$finish;
	end

	initial
	begin
		void'($urandom(97));
		repeat (16) @(posedge clk);
		sresetn <= 1'b1;

		start_test("minimal_packet");
		@(negedge clk);
		if (out_valid !== 1'b0)
			report_failure("out_valid is not low after reset");
		if (in_ready !== 1'b1)
			report_failure("in_ready is not high after reset");
		run_packets(1, 5, 5, 1, 1, 0);
		finish_test(1);

		start_test("options_strip");
		run_packets(8, 6, 8, 1, 20, 0);
		finish_test(8);

		start_test("lane_order");
		run_packets(32, 5, 8, 1, 20, 0);
		finish_test(32);

		start_test("backpressure");
		run_packets(32, 5, 8, 1, 20, 1);
		if (!saw_full)
			report_failure("in_ready never went low, so the credits never ran out");
		finish_test(32);

		start_test("stall_resume");
		run_packets(24, 5, 8, 1, 20, 2);
		finish_test(24);

		$display("tests=%0d failed_checks=%0d", tests_run, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- src.f
src/stream_pkg.sv
src/ipv4_pkg.sv
src/beat_fifo.sv
src/frame_dispatcher.sv
src/ip_deframer_lane.sv
src/payload_collector.sv
src/ip_deframer_array.sv
dv/tb_ip_deframer_array.sv

//--- Makefile
VERILATOR  = verilator
FILELIST   = src.f
TOP        = tb_ip_deframer_array
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing -j 0
SIM_BIN    = obj_dir/V$(TOP)
LOG        = sim.log
PASS_MSG   = *** PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	$(SIM_BIN) | tee $(LOG)
	grep -q -F "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
